// File: src.f
+incdir+.
snac_pkg.sv
snac_strobe_gen.sv
serlatch_sequencer.sv
serlatch_shift_rx.sv
snac_button_map.sv
snac_cart_port.sv
snac_top.sv
snac_asserts.sv
snac_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the snac testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --assert --timescale 1ns/1ps --top-module snac_tb -f src.f -o snac_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/snac_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: snac_tb.sv
`timescale 1ns/1ps
`include "snac_defines.svh"

module snac_tb;

    import snac_pkg::*;

    logic                    i_clk = 1'b0;
    logic                    i_rst;
    cart_conf_e              i_conf;
    logic [`SNAC_TYPE_W-1:0] i_gc_type;
    logic [3:0]              i_bk0_in;
    logic                    i_pin30_in;
    logic                    i_pin31_in;
    logic [`SNAC_BTN_W-1:0]  o_p1_btn;
    logic [`SNAC_BTN_W-1:0]  o_p2_btn;
    logic                    o_busy;
    logic                    o_bk0_dir;
    logic [1:0]              o_bk1_out;
    logic                    o_pin30_out;
    logic                    o_pin30_dir;
    logic                    o_pin31_out;
    logic                    o_pin31_dir;

    // pad model state
    logic [`SNAC_BTN_W-1:0]  pad_p1 = '1;
    logic [`SNAC_BTN_W-1:0]  pad_p2 = '1;
    logic                    p1_line = 1'b1;
    logic                    p2_line = 1'b1;
    logic                    lat_prev = 1'b0;
    logic                    sclk_prev = 1'b0;
    int                      timeout_cnt = 0;

    // bank0 bits 7..4 with p1 on both bit 4 and bit 6
    assign i_bk0_in = {1'b1, p1_line, p2_line, p1_line};

    initial forever #10 i_clk = ~i_clk;

    snac_top UUT (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_conf      (i_conf),
        .i_gc_type   (i_gc_type),
        .i_bk0_in    (i_bk0_in),
        .i_pin30_in  (i_pin30_in),
        .i_pin31_in  (i_pin31_in),
        .o_p1_btn    (o_p1_btn),
        .o_p2_btn    (o_p2_btn),
        .o_busy      (o_busy),
        .o_bk0_dir   (o_bk0_dir),
        .o_bk1_out   (o_bk1_out),
        .o_pin30_out (o_pin30_out),
        .o_pin30_dir (o_pin30_dir),
        .o_pin31_out (o_pin31_out),
        .o_pin31_dir (o_pin31_dir)
    );

    // two pads load new presses on the latch and shift after each clock rise
    always @(negedge i_clk) begin
        if (o_bk1_out[1] && !lat_prev) begin
            pad_p1 = 16'($urandom);
            pad_p2 = 16'($urandom);
        end else if (o_bk1_out[0] && !sclk_prev) begin
            // empty pad stages read high
            pad_p1 = {1'b1, pad_p1[15:1]};
            pad_p2 = {1'b1, pad_p2[15:1]};
        end
        p1_line   <= pad_p1[0];
        p2_line   <= pad_p2[0];
        lat_prev  <= o_bk1_out[1];
        sclk_prev <= o_bk1_out[0];
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    task automatic wait_busy(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (o_busy !== level && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        if (o_busy !== level) begin
            timeout_cnt++;
            $display("timeout at %0t: o_busy did not reach %0d within %0d cycles",
                     $time, level, max_cycles);
        end
    endtask

    task automatic wait_pad_clock(input int max_cycles);
        int n;
        n = 0;
        while (o_bk1_out[0] !== 1'b1 && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        if (o_bk1_out[0] !== 1'b1) begin
            timeout_cnt++;
            $display("timeout at %0t: pad clock did not rise within %0d cycles",
                     $time, max_cycles);
        end
    endtask

    // whole frames so the type only moves while the sequencer is idle
    task automatic run_frames(input int n);
        repeat (n) begin
            wait_busy(1'b1, 20000);
            wait_busy(1'b0, 20000);
            idle_cycles(4);
        end
    endtask

    initial begin
        int fail_total;
        void'($urandom(32'h864c));
        i_rst      = 1'b1;
        i_conf     = CONF_A;
        i_gc_type  = `SNAC_GC_DISABLED;
        i_pin30_in = 1'b1;
        i_pin31_in = 1'b1;
        idle_cycles(4);
        i_rst = 1'b0;
        idle_cycles(2000);

        i_gc_type = `SNAC_GC_NES;
        run_frames(2);

        // pin routing flips while the pad clock is high
        wait_busy(1'b1, 20000);
        wait_pad_clock(20000);
        i_conf = CONF_B;
        idle_cycles(6);
        i_conf = CONF_A;
        wait_busy(1'b0, 20000);
        idle_cycles(4);

        i_gc_type = `SNAC_GC_SNES_SWAP;
        run_frames(2);

        // disabled pads keep the lines quiet
        i_gc_type = `SNAC_GC_DISABLED;
        idle_cycles(3000);

        fail_total = UUT.u_asserts.fail_cnt;
        $display("assertion failures: %0d, timeouts: %0d", fail_total, timeout_cnt);
        if (fail_total == 0 && timeout_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: snac_asserts.sv
`timescale 1ns/1ps
`include "snac_defines.svh"

module snac_asserts (
    input logic                    i_clk,
    input logic                    i_rst,
    input snac_pkg::cart_conf_e    i_conf,
    input logic [`SNAC_TYPE_W-1:0] i_gc_type,
    input logic [3:0]              i_bk0_in,
    input logic                    i_pin31_in,
    input logic [`SNAC_BTN_W-1:0]  i_p1_btn,
    input logic [`SNAC_BTN_W-1:0]  i_p2_btn,
    input logic                    i_busy,
    input logic                    i_bk0_dir,
    input logic [1:0]              i_bk1_out,
    input logic                    i_pin30_out,
    input logic                    i_pin30_dir,
    input logic                    i_pin31_out,
    input logic                    i_pin31_dir
);

    import snac_pkg::*;

    // snes buttons by arrival slot
    localparam int BIT_B = 0;
    localparam int BIT_Y = 1;
    localparam int BIT_A = 8;
    localparam int BIT_X = 9;

    // failed checks, read by the testbench at the end
    int fail_cnt = 0;

    logic                   pad_lat;
    logic                   pad_sclk;
    logic                   db15;
    logic                   pin_p1;
    logic                   pin_p2;
    logic                   lat_d;
    logic                   sclk_d;
    logic                   busy_d;
    logic                   p1_d;
    logic                   p2_d;
    logic [4:0]             bit_idx;
    logic [`SNAC_BTN_W-1:0] rec_p1;
    logic [`SNAC_BTN_W-1:0] rec_p2;
    int                     lat_rises;
    int                     clk_rises;

    // pad lines as they leave the cartridge port
    assign pad_lat  = i_bk1_out[1];
    assign pad_sclk = i_bk1_out[0];
    assign db15     = (i_gc_type == `SNAC_GC_DB15) || (i_gc_type == `SNAC_GC_DB15_FAST);

    // data pin per player, conf a p1 may also be pulled low through pin 31
    assign pin_p1 = (i_conf == CONF_B) ? i_bk0_in[2] : (i_bk0_in[0] & (i_pin31_in | ~db15));
    assign pin_p2 = i_bk0_in[1];

    // expected buttons from the pin levels of one frame
    function automatic logic [`SNAC_BTN_W-1:0] pad_to_buttons(
        input logic [`SNAC_BTN_W-1:0]  lvl,
        input logic [`SNAC_TYPE_W-1:0] t
    );
        logic [`SNAC_BTN_W-1:0] act;
        logic [`SNAC_BTN_W-1:0] res;
        act = ~lvl;
        res = act;
        if (t == `SNAC_GC_SNES_SWAP) begin
            res[BIT_A] = act[BIT_B];
            res[BIT_B] = act[BIT_A];
            res[BIT_X] = act[BIT_Y];
            res[BIT_Y] = act[BIT_X];
        end
        if (t != `SNAC_GC_DB15 && t != `SNAC_GC_DB15_FAST && t != `SNAC_GC_NES &&
            t != `SNAC_GC_SNES && t != `SNAC_GC_SNES_SWAP) begin
            res = '0;
        end
        return res;
    endfunction

    // edges seen one cycle late, the pin level from that edge sits in p*_d
    always_ff @(posedge i_clk) begin
        lat_d  <= pad_lat;
        sclk_d <= pad_sclk;
        busy_d <= i_busy;
        p1_d   <= pin_p1;
        p2_d   <= pin_p2;
        if (i_rst) begin
            bit_idx   <= '0;
            rec_p1    <= '0;
            rec_p2    <= '0;
            lat_rises <= 0;
            clk_rises <= 0;
        end else begin
            // new frame clears the edge counts
            if (i_busy && !busy_d) begin
                lat_rises <= 0;
                clk_rises <= 0;
            end else begin
                if (pad_lat && !lat_d) begin
                    lat_rises <= lat_rises + 1;
                end
                if (pad_sclk && !sclk_d) begin
                    clk_rises <= clk_rises + 1;
                end
            end
            // bit 0 at the latch fall, later bits on clock rises
            if (!pad_lat && lat_d) begin
                rec_p1  <= {15'd0, p1_d};
                rec_p2  <= {15'd0, p2_d};
                bit_idx <= 5'd1;
            end else if (pad_sclk && !sclk_d && bit_idx < 5'd16) begin
                rec_p1[bit_idx[3:0]] <= p1_d;
                rec_p2[bit_idx[3:0]] <= p2_d;
                bit_idx              <= bit_idx + 5'd1;
            end
        end
    end

    a_reset: assert property (@(posedge i_clk)
        $fell(i_rst) |-> !i_busy && i_bk1_out == 2'b00 && i_p1_btn == '0 && i_p2_btn == '0)
        else begin
            fail_cnt++;
            $error("FAIL %0t: lines or buttons not idle after reset", $time);
        end

    // one latch pulse then 15 clock rises per frame
    a_frame: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_busy) |-> lat_rises == 1 && clk_rises == 15)
        else begin
            fail_cnt++;
            $error("FAIL %0t: frame had %0d latch and %0d clock rises", $time,
                   lat_rises, clk_rises);
        end

    // outputs settle two cycles after busy drops
    a_buttons: assert property (@(posedge i_clk) disable iff (i_rst)
        ($past(i_busy, 3) && !$past(i_busy, 2)) |->
            i_p1_btn == pad_to_buttons(rec_p1, i_gc_type) &&
            i_p2_btn == pad_to_buttons(rec_p2, i_gc_type))
        else begin
            fail_cnt++;
            $error("FAIL %0t: buttons %h %h from pins %h %h", $time,
                   i_p1_btn, i_p2_btn, rec_p1, rec_p2);
        end

    a_conf: assert property (@(posedge i_clk) disable iff (i_rst)
        $changed(i_conf) |=> !i_bk0_dir && ((i_conf == CONF_A) ?
            (i_pin30_dir && i_pin30_out == i_bk1_out[0] && !i_pin31_dir) :
            (i_pin30_dir && i_pin31_dir && !i_pin30_out && !i_pin31_out)))
        else begin
            fail_cnt++;
            $error("FAIL %0t: pin directions wrong for conf %0d", $time, i_conf);
        end

    // disabled pad, no latch and no buttons once the change has passed through
    a_disabled: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_gc_type == `SNAC_GC_DISABLED && $past(i_gc_type, 1) == `SNAC_GC_DISABLED &&
         $past(i_gc_type, 2) == `SNAC_GC_DISABLED && $past(i_gc_type, 3) == `SNAC_GC_DISABLED)
        |-> !i_busy && !i_bk1_out[1] && i_p1_btn == '0 && i_p2_btn == '0)
        else begin
            fail_cnt++;
            $error("FAIL %0t: disabled pad still active", $time);
        end

endmodule

bind snac_top snac_asserts u_asserts (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_conf      (i_conf),
    .i_gc_type   (i_gc_type),
    .i_bk0_in    (i_bk0_in),
    .i_pin31_in  (i_pin31_in),
    .i_p1_btn    (o_p1_btn),
    .i_p2_btn    (o_p2_btn),
    .i_busy      (o_busy),
    .i_bk0_dir   (o_bk0_dir),
    .i_bk1_out   (o_bk1_out),
    .i_pin30_out (o_pin30_out),
    .i_pin30_dir (o_pin30_dir),
    .i_pin31_out (o_pin31_out),
    .i_pin31_dir (o_pin31_dir)
);

// File: snac_top.sv
`timescale 1ns/1ps
`include "snac_defines.svh"

module snac_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  snac_pkg::cart_conf_e    i_conf,
    input  logic [`SNAC_TYPE_W-1:0] i_gc_type,
    input  logic [3:0]              i_bk0_in,
    input  logic                    i_pin30_in,
    input  logic                    i_pin31_in,
    output logic [`SNAC_BTN_W-1:0]  o_p1_btn,
    output logic [`SNAC_BTN_W-1:0]  o_p2_btn,
    output logic                    o_busy,
    output logic                    o_bk0_dir,
    output logic [1:0]              o_bk1_out,
    output logic                    o_pin30_out,
    output logic                    o_pin30_dir,
    output logic                    o_pin31_out,
    output logic                    o_pin31_dir
);

    import snac_pkg::*;

    logic                     stb;
    logic                     sync_rst;
    logic                     lat;
    logic                     sclk;
    logic                     sample;
    logic                     frame_done;
    logic                     db15;
    logic [`SNAC_PLAYERS-1:0] dat;
    btn_word_t                held_word [`SNAC_PLAYERS];

    // db15 pads may answer on the crossed line as well
    assign db15 = (i_gc_type == `SNAC_GC_DB15) || (i_gc_type == `SNAC_GC_DB15_FAST);

    snac_strobe_gen u_strobe_gen (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_gc_type  (i_gc_type),
        .o_stb      (stb),
        .o_sync_rst (sync_rst)
    );

    // latch and clock are shared by both pads
    serlatch_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_sync_rst   (sync_rst),
        .i_stb        (stb),
        .o_lat        (lat),
        .o_sclk       (sclk),
        .o_sample     (sample),
        .o_frame_done (frame_done),
        .o_busy       (o_busy)
    );

    // one receiver per pad data line
    for (genvar i = 0; i < `SNAC_PLAYERS; i++) begin : g_rx
        serlatch_shift_rx u_rx (
            .i_clk        (i_clk),
            .i_sync_rst   (sync_rst),
            .i_sample     (sample),
            .i_frame_done (frame_done),
            .i_dat        (dat[i]),
            .o_word       (held_word[i])
        );
    end

    snac_button_map u_button_map (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_gc_type (i_gc_type),
        .i_word_p1 (held_word[0]),
        .i_word_p2 (held_word[1]),
        .o_p1_btn  (o_p1_btn),
        .o_p2_btn  (o_p2_btn)
    );

    snac_cart_port u_cart_port (
        .i_clk       (i_clk),
        .i_conf      (i_conf),
        .i_db15      (db15),
        .i_lat       (lat),
        .i_sclk      (sclk),
        .i_bk0_in    (i_bk0_in),
        .i_pin30_in  (i_pin30_in),
        .i_pin31_in  (i_pin31_in),
        .o_dat_p1    (dat[0]),
        .o_dat_p2    (dat[1]),
        .o_bk0_dir   (o_bk0_dir),
        .o_bk1_out   (o_bk1_out),
        .o_pin30_out (o_pin30_out),
        .o_pin30_dir (o_pin30_dir),
        .o_pin31_out (o_pin31_out),
        .o_pin31_dir (o_pin31_dir)
    );

endmodule

// File: snac_cart_port.sv
`timescale 1ns/1ps

module snac_cart_port (
    input  logic                 i_clk,
    input  snac_pkg::cart_conf_e i_conf,
    input  logic                 i_db15,
    input  logic                 i_lat,
    input  logic                 i_sclk,
    input  logic [3:0]           i_bk0_in,
    input  logic                 i_pin30_in,
    input  logic                 i_pin31_in,
    output logic                 o_dat_p1,
    output logic                 o_dat_p2,
    output logic                 o_bk0_dir,
    output logic [1:0]           o_bk1_out,
    output logic                 o_pin30_out,
    output logic                 o_pin30_dir,
    output logic                 o_pin31_out,
    output logic                 o_pin31_dir
);

    import snac_pkg::*;

    // i_bk0_in[0] is bank0 bit 4, o_bk1_out[1] is bank1 bit 7
    always_ff @(posedge i_clk) begin
        // bank0 is always input, bank1 carries latch over clock
        o_bk0_dir <= 1'b0;
        o_bk1_out <= {i_lat, i_sclk};
        o_dat_p2  <= i_bk0_in[1];
        case (i_conf)
            CONF_A: begin
                // db15 cables may cross rx and tx, so data can come in on pin 31
                o_dat_p1    <= i_bk0_in[0] & (i_pin31_in | ~i_db15);
                o_pin30_out <= i_sclk;
                o_pin30_dir <= 1'b1;
                o_pin31_out <= 1'b0;
                o_pin31_dir <= 1'b0;
            end
            CONF_B: begin
                o_dat_p1    <= i_bk0_in[2];
                o_pin30_out <= 1'b0;
                o_pin30_dir <= 1'b1;
                o_pin31_out <= 1'b0;
                o_pin31_dir <= 1'b1;
            end
            default: begin
                o_dat_p1    <= 1'b1;
                o_pin30_out <= 1'b0;
                o_pin30_dir <= 1'b0;
                o_pin31_out <= 1'b0;
                o_pin31_dir <= 1'b0;
            end
        endcase
    end

endmodule

// File: snac_button_map.sv
`timescale 1ns/1ps
`include "snac_defines.svh"

module snac_button_map (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic [`SNAC_TYPE_W-1:0] i_gc_type,
    input  snac_pkg::btn_word_t     i_word_p1,
    input  snac_pkg::btn_word_t     i_word_p2,
    output logic [`SNAC_BTN_W-1:0]  o_p1_btn,
    output logic [`SNAC_BTN_W-1:0]  o_p2_btn
);

    import snac_pkg::*;

    logic swap;

    // pads pull low on press, buttons are reported high
    // swap trades a with b and x with y for pads wired the other way round
    function automatic logic [`SNAC_BTN_W-1:0] map_word(input btn_word_t w, input logic sw);
        btn_word_t act;
        btn_word_t res;
        act.raw = ~w.raw;
        res     = act;
        if (sw) begin
            res.snes.a = act.snes.b;
            res.snes.b = act.snes.a;
            res.snes.x = act.snes.y;
            res.snes.y = act.snes.x;
        end
        return res.raw;
    endfunction

    assign swap = (i_gc_type == `SNAC_GC_SNES_SWAP);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_p1_btn <= '0;
            o_p2_btn <= '0;
        end else begin
            case (i_gc_type)
                `SNAC_GC_DB15,
                `SNAC_GC_DB15_FAST,
                `SNAC_GC_NES,
                `SNAC_GC_SNES,
                `SNAC_GC_SNES_SWAP: begin
                    o_p1_btn <= map_word(i_word_p1, swap);
                    o_p2_btn <= map_word(i_word_p2, swap);
                end
                // disabled or unknown pad
                default: begin
                    o_p1_btn <= '0;
                    o_p2_btn <= '0;
                end
            endcase
        end
    end

endmodule

// File: serlatch_shift_rx.sv
`timescale 1ns/1ps
`include "snac_defines.svh"

module serlatch_shift_rx (
    input  logic               i_clk,
    input  logic               i_sync_rst,
    input  logic               i_sample,
    input  logic               i_frame_done,
    input  logic               i_dat,
    output snac_pkg::btn_word_t o_word
);

    // frame in progress, the newest bit enters at the top
    logic [`SNAC_BTN_W-1:0] sr;

    // after 16 shifts the first bit has walked down to bit 0
    always_ff @(posedge i_clk) begin
        if (i_sample) begin
            sr <= {i_dat, sr[`SNAC_BTN_W-1:1]};
        end
    end

    // held word only moves on a complete frame
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            o_word <= '0;
        end else if (i_frame_done) begin
            o_word.raw <= sr;
        end
    end

endmodule

// File: serlatch_sequencer.sv
`timescale 1ns/1ps
`include "snac_defines.svh"

module serlatch_sequencer (
    input  logic i_clk,
    input  logic i_sync_rst,
    input  logic i_stb,
    output logic o_lat,
    output logic o_sclk,
    output logic o_sample,
    output logic o_frame_done,
    output logic o_busy
);

    localparam int CNT_W = $clog2(`SNAC_FRAME_STROBES);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`SNAC_FRAME_STROBES - 1);

    // index of the next strobe inside the frame
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            cnt          <= '0;
            o_lat        <= 1'b0;
            o_sclk       <= 1'b0;
            o_sample     <= 1'b0;
            o_frame_done <= 1'b0;
            o_busy       <= 1'b0;
        end else begin
            // pulses last one cycle
            o_sample     <= 1'b0;
            o_frame_done <= 1'b0;
            if (i_stb) begin
                if (!o_busy) begin
                    // strobe 0, latch the pad shift registers
                    o_lat  <= 1'b1;
                    o_busy <= 1'b1;
                    cnt    <= CNT_W'(1);
                end else if (cnt == '0) begin
                    // strobe after the last one closes the frame
                    o_frame_done <= 1'b1;
                    o_busy       <= 1'b0;
                    o_sclk       <= 1'b0;
                end else if (cnt == CNT_W'(1)) begin
                    // latch release, bit 0 is already on the line
                    o_lat    <= 1'b0;
                    o_sample <= 1'b1;
                    cnt      <= cnt + 1'b1;
                end else if (!cnt[0]) begin
                    // even strobe, clock low half
                    o_sclk <= 1'b0;
                    cnt    <= cnt + 1'b1;
                end else begin
                    // odd strobe, rising clock and sample of the next bit
                    o_sclk   <= 1'b1;
                    o_sample <= 1'b1;
                    if (cnt == LAST) begin
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: snac_strobe_gen.sv
`timescale 1ns/1ps
`include "snac_defines.svh"

module snac_strobe_gen (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic [`SNAC_TYPE_W-1:0] i_gc_type,
    output logic                    o_stb,
    output logic                    o_sync_rst
);

    logic [`SNAC_TYPE_W-1:0] type_r;
    logic [31:0]             step;
    logic [31:0]             acc;

    // registered copy of the type, a mismatch means the host switched pads
    always_ff @(posedge i_clk) begin
        type_r     <= i_gc_type;
        o_sync_rst <= i_rst || (i_gc_type != type_r);
    end

    // step per type, zero keeps the divider silent
    always_comb begin
        case (type_r)
            `SNAC_GC_DB15:      step = `SNAC_STEP_DB15;
            `SNAC_GC_DB15_FAST: step = `SNAC_STEP_DB15_FAST;
            `SNAC_GC_NES,
            `SNAC_GC_SNES,
            `SNAC_GC_SNES_SWAP: step = `SNAC_STEP_SNES;
            default:            step = 32'd0;
        endcase
    end

    // fractional divider, the carry out of the phase sum is the strobe
    always_ff @(posedge i_clk) begin
        if (i_rst || o_sync_rst) begin
            acc   <= 32'd0;
            o_stb <= 1'b0;
        end else begin
            {o_stb, acc} <= {1'b0, acc} + {1'b0, step};
        end
    end

endmodule

// File: snac_pkg.sv
`include "snac_defines.svh"

package snac_pkg;

    // snes pad layout, b arrives first and so sits at bit 0
    typedef struct packed {
        logic [`SNAC_BTN_W-13:0] unused;
        logic r;
        logic l;
        logic x;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic sel;
        logic y;
        logic b;
    } snes_btn_t;

    // received button word
    // raw is arrival order, snes names the same bits by button
    typedef union packed {
        logic [`SNAC_BTN_W-1:0] raw;
        snes_btn_t snes;
    } btn_word_t;

    // cartridge port wiring variant
    typedef enum logic {
        CONF_A = 1'b0,
        CONF_B = 1'b1
    } cart_conf_e;

endpackage

// File: snac_defines.svh
`ifndef SNAC_DEFINES_SVH
`define SNAC_DEFINES_SVH

// master clock of the core in hz
`define SNAC_CLK_FREQ 50_000_000

// polling rates, the protocol strobe runs at twice these
`define SNAC_POLL_DB15 200_000
`define SNAC_POLL_DB15_FAST 400_000
`define SNAC_POLL_SNES 50_000

// 32-bit phase step for a strobe at twice the polling rate f
`define SNAC_STEP_CALC(f) (32'((64'd1 << 32) * 64'(f) * 64'd2 / 64'(`SNAC_CLK_FREQ)))
`define SNAC_STEP_DB15 `SNAC_STEP_CALC(`SNAC_POLL_DB15)
`define SNAC_STEP_DB15_FAST `SNAC_STEP_CALC(`SNAC_POLL_DB15_FAST)
`define SNAC_STEP_SNES `SNAC_STEP_CALC(`SNAC_POLL_SNES)

// word widths and player count
`define SNAC_BTN_W 16
`define SNAC_PLAYERS 2
`define SNAC_TYPE_W 5

// controller type codes
`define SNAC_GC_DISABLED 5'd0
`define SNAC_GC_DB15 5'd1
`define SNAC_GC_NES 5'd2
`define SNAC_GC_SNES 5'd3
`define SNAC_GC_DB15_FAST 5'd9
`define SNAC_GC_SNES_SWAP 5'd11

// strobes in one serial-latch frame, latch plus 16 bit slots of two strobes
`define SNAC_FRAME_STROBES 32

`endif
